//--- include/slurm16_mem_defs.svh
// slurm16 memory subsystem sizing
// Word width, CPU address width and depth of each bank
`ifndef SLURM16_MEM_DEFS_SVH
`define SLURM16_MEM_DEFS_SVH

// Data word width
`define SLURM_BITS 16

// CPU word address width
// Top bit picks the bank
`define SLURM_ADDRESS_BITS 15

// Words held by one bank
// Half of the CPU address space
`define SLURM_BANK_WORDS 16384

`endif

//--- design/slurm16_mem_pkg.sv
// slurm16 memory subsystem types
// Shared by the CPU interface, bank arbiter and RAM banks
`include "slurm16_mem_defs.svh"

package slurm16_mem_pkg;

	// One data word
	typedef logic [`SLURM_BITS-1:0] word_t;

	// CPU word address
	typedef logic [`SLURM_ADDRESS_BITS-1:0] addr_t;

	// Memory port address, top bit always zero
	typedef logic [`SLURM_ADDRESS_BITS:0] mem_addr_t;

	// Byte enables
	// Bit 0 low byte, bit 1 high byte
	typedef logic [1:0] wr_mask_t;

	// Pipeline slot flags, rd ends up in bit 0
	typedef struct packed {
		logic req;
		logic instr;
		logic rd;
	} mem_flags_t;

endpackage

//--- design/memory_bank.sv
// slurm16 memory bank
// Single-port synchronous RAM with per-byte write enables
`include "slurm16_mem_defs.svh"

module memory_bank
	import slurm16_mem_pkg::*;
(
	input  logic                                CLK,
	input  logic [$clog2(`SLURM_BANK_WORDS)-1:0] addr,
	input  word_t                               wdata,
	input  logic                                we,
	input  wr_mask_t                            wr_mask,
	output word_t                               rdata
);

	word_t mem [`SLURM_BANK_WORDS];

	always_ff @(posedge CLK) begin
		if (we) begin
			// Only the enabled bytes change
			if (wr_mask[0])
				mem[addr][7:0] <= wdata[7:0];
			if (wr_mask[1])
				mem[addr][`SLURM_BITS-1:8] <= wdata[`SLURM_BITS-1:8];
		end
	end

	// Read data one cycle after the address, old contents on a write
	always_ff @(posedge CLK) begin
		rdata <= mem[addr];
	end

endmodule

//--- design/bank_arbiter.sv
// slurm16 bank arbiter
// Gives each of the two RAM banks to the CPU or the external master,
// CPU first on a tie, and steers the owner's bus onto the bank
`include "slurm16_mem_defs.svh"

module bank_arbiter
	import slurm16_mem_pkg::*;
(
	input  logic                          CLK,
	input  logic                          RSTb,

	input  logic                          cpu_valid,
	input  addr_t                         cpu_address,
	input  word_t                         cpu_data,
	input  logic                          cpu_wr,
	input  wr_mask_t                      cpu_wr_mask,
	output logic                          cpu_rdy,
	output word_t                         cpu_rdata,

	input  logic                          ext_valid,
	input  addr_t                         ext_address,
	input  word_t                         ext_data,
	input  logic                          ext_wr,
	input  wr_mask_t                      ext_wr_mask,
	output logic                          ext_rdy,
	output word_t                         ext_rdata,

	output logic [`SLURM_ADDRESS_BITS-2:0] bank0_addr,
	output word_t                         bank0_wdata,
	output logic                          bank0_we,
	output wr_mask_t                      bank0_wr_mask,
	input  word_t                         bank0_rdata,

	output logic [`SLURM_ADDRESS_BITS-2:0] bank1_addr,
	output word_t                         bank1_wdata,
	output logic                          bank1_we,
	output wr_mask_t                      bank1_wr_mask,
	input  word_t                         bank1_rdata
);

	typedef enum logic [1:0] {own_none, own_cpu, own_ext} owner_t;

	owner_t owner [2];

	logic cpu_bank, ext_bank;
	// Bank of last cycle's address, picks the read data
	logic cpu_bank_q, ext_bank_q;

	assign cpu_bank = cpu_address[`SLURM_ADDRESS_BITS-1];
	assign ext_bank = ext_address[`SLURM_ADDRESS_BITS-1];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			owner[0] <= own_none;
			owner[1] <= own_none;
		end else begin
			for (int b = 0; b < 2; b++) begin
				case (owner[b])
					own_none: begin
						// Fixed priority on a free bank
						if (cpu_valid && (cpu_bank == b[0]))
							owner[b] <= own_cpu;
						else if (ext_valid && (ext_bank == b[0]))
							owner[b] <= own_ext;
					end
					// Held until valid drops
					own_cpu: if (!cpu_valid) owner[b] <= own_none;
					own_ext: if (!ext_valid) owner[b] <= own_none;
					default: owner[b] <= own_none;
				endcase
			end
		end
	end

	always_ff @(posedge CLK) begin
		cpu_bank_q <= cpu_bank;
		ext_bank_q <= ext_bank;
	end

	assign cpu_rdy = cpu_valid && (owner[cpu_bank] == own_cpu);
	assign ext_rdy = ext_valid && (owner[ext_bank] == own_ext);

	assign cpu_rdata = cpu_bank_q ? bank1_rdata : bank0_rdata;
	assign ext_rdata = ext_bank_q ? bank1_rdata : bank0_rdata;

	// Bank 0 follows its owner, CPU bus by default
	assign bank0_addr    = (owner[0] == own_ext) ? ext_address[`SLURM_ADDRESS_BITS-2:0] :
		cpu_address[`SLURM_ADDRESS_BITS-2:0];
	assign bank0_wdata   = (owner[0] == own_ext) ? ext_data : cpu_data;
	assign bank0_wr_mask = (owner[0] == own_ext) ? ext_wr_mask : cpu_wr_mask;
	// No write unless the owner actually points here
	assign bank0_we = ((owner[0] == own_cpu) && cpu_wr && !cpu_bank) ||
		((owner[0] == own_ext) && ext_wr && !ext_bank);

	assign bank1_addr    = (owner[1] == own_ext) ? ext_address[`SLURM_ADDRESS_BITS-2:0] :
		cpu_address[`SLURM_ADDRESS_BITS-2:0];
	assign bank1_wdata   = (owner[1] == own_ext) ? ext_data : cpu_data;
	assign bank1_wr_mask = (owner[1] == own_ext) ? ext_wr_mask : cpu_wr_mask;
	assign bank1_we = ((owner[1] == own_cpu) && cpu_wr && cpu_bank) ||
		((owner[1] == own_ext) && ext_wr && ext_bank);

endmodule

//--- design/cpu_memory_interface.sv
// slurm16 CPU memory interface
// Merges instruction fetches and data accesses into a two-stage pipeline
// onto one memory port, handling bank ownership and bank switches
`include "slurm16_mem_defs.svh"

module cpu_memory_interface
	import slurm16_mem_pkg::*;
(
	input  logic      CLK,
	input  logic      RSTb,

	// Instruction channel
	input  addr_t     instruction_memory_address,
	input  logic      instruction_memory_read_req,
	output word_t     instruction_memory_data,
	output addr_t     instruction_memory_address_out,
	output logic      instruction_memory_success,
	output logic      instruction_will_queue,

	// Data channel
	input  addr_t     data_memory_address,
	input  word_t     data_memory_in,
	input  logic      data_memory_read_req,
	input  logic      data_memory_write_req,
	input  wr_mask_t  data_memory_wr_mask,
	output word_t     data_memory_data_out,
	output logic      data_memory_success,
	output logic      data_memory_was_requested,
	output wr_mask_t  data_memory_wr_mask_out,

	// High while giving up one bank and waiting for the next
	output logic      bank_sw,

	// Memory port
	output mem_addr_t memory_address,
	output word_t     data_out,
	input  word_t     data_in,
	output wr_mask_t  wr_mask,
	output logic      mem_wr,
	output logic      valid,
	input  logic      rdy,

	input  logic      halt
);

	typedef enum logic [1:0] {
		st_idle,
		st_request_bank,
		st_execute,
		st_bank_switch
	} state_t;

	state_t state, next_state;

	// Stage 1 drives the memory port
	addr_t      s1_addr, s1_addr_next;
	word_t      s1_data, s1_data_next;
	mem_flags_t s1_flags, s1_flags_next;
	wr_mask_t   s1_mask, s1_mask_next;

	// Stage 2 lines up with the read data
	addr_t      s2_addr;
	mem_flags_t s2_flags;
	wr_mask_t   s2_mask;

	// Incoming request after priority
	addr_t      pick_addr;
	word_t      pick_data;
	mem_flags_t pick_flags;
	wr_mask_t   pick_mask;

	logic bank_switch_required;
	logic bank_switch_required_next;

	// Stage 1 went to a bank other than the one stage 2 was served from
	assign bank_switch_required_next = s1_flags.req &&
		(s1_addr[`SLURM_ADDRESS_BITS-1] != s2_addr[`SLURM_ADDRESS_BITS-1]);

	// Data requests beat fetches
	always_comb begin
		pick_addr  = data_memory_address;
		pick_data  = data_memory_in;
		pick_flags = '0;
		pick_mask  = data_memory_wr_mask;
		if (data_memory_read_req || data_memory_write_req) begin
			pick_flags.req   = 1'b1;
			pick_flags.instr = 1'b0;
			pick_flags.rd    = data_memory_read_req;
		end else if (instruction_memory_read_req) begin
			pick_addr        = instruction_memory_address;
			pick_mask        = 2'b00;
			pick_flags.req   = 1'b1;
			pick_flags.instr = 1'b1;
			pick_flags.rd    = 1'b1;
		end
	end

	always_comb begin
		next_state             = state;
		s1_addr_next           = s1_addr;
		s1_data_next           = s1_data;
		s1_flags_next          = s1_flags;
		s1_mask_next           = s1_mask;
		instruction_will_queue = 1'b0;

		case (state)
			st_idle: begin
				s1_flags_next = '0;
				if (pick_flags.req) begin
					next_state    = st_request_bank;
					s1_addr_next  = pick_addr;
					s1_data_next  = pick_data;
					s1_flags_next = pick_flags;
					s1_mask_next  = pick_mask;
				end
			end
			st_request_bank: begin
				// Follow the CPU while waiting, the arbiter looks at our address
				if (pick_flags.req) begin
					s1_addr_next  = pick_addr;
					s1_data_next  = pick_data;
					s1_flags_next = pick_flags;
					s1_mask_next  = pick_mask;
				end
				if (rdy)
					next_state = st_execute;
			end
			st_execute: begin
				if (bank_switch_required) begin
					// Replay the access that crossed, as a read for now
					next_state       = st_bank_switch;
					s1_addr_next     = s2_addr;
					s1_flags_next    = s2_flags;
					s1_flags_next.rd = 1'b1;
					s1_mask_next     = s2_mask;
				end else if (pick_flags.req) begin
					s1_addr_next           = pick_addr;
					s1_data_next           = pick_data;
					s1_flags_next          = pick_flags;
					s1_mask_next           = pick_mask;
					instruction_will_queue = pick_flags.instr;
				end else begin
					// Empty slot, address kept so the bank bit stays put
					s1_flags_next = '0;
					if (halt)
						next_state = st_idle;
				end
			end
			st_bank_switch: begin
				// Valid low for this cycle frees the old bank
				next_state = st_request_bank;
			end
			default: next_state = st_idle;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state                <= st_idle;
			s1_flags             <= '0;
			s2_flags             <= '0;
			bank_switch_required <= 1'b0;
		end else begin
			state                <= next_state;
			s1_flags             <= s1_flags_next;
			s2_flags             <= s1_flags;
			bank_switch_required <= bank_switch_required_next;
		end
	end

	// Payload advances every cycle
	always_ff @(posedge CLK) begin
		s1_addr <= s1_addr_next;
		s1_data <= s1_data_next;
		s1_mask <= s1_mask_next;
		s2_addr <= s1_addr;
		s2_mask <= s1_mask;
	end

	assign memory_address = {1'b0, s1_addr};
	assign data_out       = s1_data;
	assign wr_mask        = s1_mask;

	// Write only while the bank is ours and stage 1 stays in it
	assign mem_wr = s1_flags.req && !s1_flags.rd && !bank_switch_required_next &&
		!bank_switch_required &&
		((state == st_execute) || ((state == st_request_bank) && rdy));

	assign valid   = (state == st_request_bank) || (state == st_execute);
	assign bank_sw = (state == st_request_bank) || (state == st_bank_switch);

	// Read data is shared by both channels
	assign instruction_memory_data = data_in;
	assign data_memory_data_out    = data_in;

	assign instruction_memory_address_out = s2_addr;
	assign data_memory_wr_mask_out        = s2_mask;
	assign data_memory_was_requested      = s2_flags.req && !s2_flags.instr;

	assign instruction_memory_success = (state == st_execute) && s2_flags.req &&
		s2_flags.instr && !bank_switch_required;
	assign data_memory_success = (state == st_execute) && s2_flags.req &&
		!s2_flags.instr && !bank_switch_required;

endmodule

//--- design/memory_subsystem_top.sv
// slurm16 memory subsystem
// CPU memory interface and external master sharing two RAM banks
// through the bank arbiter
`include "slurm16_mem_defs.svh"

module memory_subsystem_top
	import slurm16_mem_pkg::*;
(
	input  logic     CLK,
	input  logic     RSTb,

	input  addr_t    instruction_memory_address,
	input  logic     instruction_memory_read_req,
	output word_t    instruction_memory_data,
	output addr_t    instruction_memory_address_out,
	output logic     instruction_memory_success,
	output logic     instruction_will_queue,

	input  addr_t    data_memory_address,
	input  word_t    data_memory_in,
	input  logic     data_memory_read_req,
	input  logic     data_memory_write_req,
	input  wr_mask_t data_memory_wr_mask,
	output word_t    data_memory_data_out,
	output logic     data_memory_success,
	output logic     data_memory_was_requested,
	output wr_mask_t data_memory_wr_mask_out,

	output logic     bank_sw,
	input  logic     halt,

	// External master, DMA or video engine
	input  addr_t    ext_address,
	input  word_t    ext_data_in,
	input  logic     ext_wr,
	input  wr_mask_t ext_wr_mask,
	input  logic     ext_valid,
	output logic     ext_rdy,
	output word_t    ext_data_out
);

	// CPU side memory port
	mem_addr_t cpu_mem_address;
	word_t     cpu_wdata;
	word_t     cpu_rdata;
	wr_mask_t  cpu_wr_mask;
	logic      cpu_mem_wr;
	logic      cpu_valid;
	logic      cpu_rdy;

	// Bank buses
	logic [`SLURM_ADDRESS_BITS-2:0] bank0_addr, bank1_addr;
	word_t    bank0_wdata, bank1_wdata;
	word_t    bank0_rdata, bank1_rdata;
	logic     bank0_we, bank1_we;
	wr_mask_t bank0_wr_mask, bank1_wr_mask;

	cpu_memory_interface u_cpu_mem (
		.CLK                            (CLK),
		.RSTb                           (RSTb),
		.instruction_memory_address     (instruction_memory_address),
		.instruction_memory_read_req    (instruction_memory_read_req),
		.instruction_memory_data        (instruction_memory_data),
		.instruction_memory_address_out (instruction_memory_address_out),
		.instruction_memory_success     (instruction_memory_success),
		.instruction_will_queue         (instruction_will_queue),
		.data_memory_address            (data_memory_address),
		.data_memory_in                 (data_memory_in),
		.data_memory_read_req           (data_memory_read_req),
		.data_memory_write_req          (data_memory_write_req),
		.data_memory_wr_mask            (data_memory_wr_mask),
		.data_memory_data_out           (data_memory_data_out),
		.data_memory_success            (data_memory_success),
		.data_memory_was_requested      (data_memory_was_requested),
		.data_memory_wr_mask_out        (data_memory_wr_mask_out),
		.bank_sw                        (bank_sw),
		.memory_address                 (cpu_mem_address),
		.data_out                       (cpu_wdata),
		.data_in                        (cpu_rdata),
		.wr_mask                        (cpu_wr_mask),
		.mem_wr                         (cpu_mem_wr),
		.valid                          (cpu_valid),
		.rdy                            (cpu_rdy),
		.halt                           (halt)
	);

	// Zero top bit of the memory address is not carried further
	bank_arbiter u_arbiter (
		.CLK           (CLK),
		.RSTb          (RSTb),
		.cpu_valid     (cpu_valid),
		.cpu_address   (cpu_mem_address[`SLURM_ADDRESS_BITS-1:0]),
		.cpu_data      (cpu_wdata),
		.cpu_wr        (cpu_mem_wr),
		.cpu_wr_mask   (cpu_wr_mask),
		.cpu_rdy       (cpu_rdy),
		.cpu_rdata     (cpu_rdata),
		.ext_valid     (ext_valid),
		.ext_address   (ext_address),
		.ext_data      (ext_data_in),
		.ext_wr        (ext_wr),
		.ext_wr_mask   (ext_wr_mask),
		.ext_rdy       (ext_rdy),
		.ext_rdata     (ext_data_out),
		.bank0_addr    (bank0_addr),
		.bank0_wdata   (bank0_wdata),
		.bank0_we      (bank0_we),
		.bank0_wr_mask (bank0_wr_mask),
		.bank0_rdata   (bank0_rdata),
		.bank1_addr    (bank1_addr),
		.bank1_wdata   (bank1_wdata),
		.bank1_we      (bank1_we),
		.bank1_wr_mask (bank1_wr_mask),
		.bank1_rdata   (bank1_rdata)
	);

	memory_bank u_bank0 (
		.CLK     (CLK),
		.addr    (bank0_addr),
		.wdata   (bank0_wdata),
		.we      (bank0_we),
		.wr_mask (bank0_wr_mask),
		.rdata   (bank0_rdata)
	);

	memory_bank u_bank1 (
		.CLK     (CLK),
		.addr    (bank1_addr),
		.wdata   (bank1_wdata),
		.we      (bank1_we),
		.wr_mask (bank1_wr_mask),
		.rdata   (bank1_rdata)
	);

endmodule

//--- bench/memory_subsystem_tb.sv
// slurm16 memory subsystem testbench
// Replays operations from a vector file against the DUT and a word-array
// reference model, with random external writes and a watchdog
`include "slurm16_mem_defs.svh"

module memory_subsystem_tb
	import slurm16_mem_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int REQ_LIMIT = 64;

	logic     CLK;
	logic     RSTb;
	addr_t    instruction_memory_address;
	logic     instruction_memory_read_req;
	word_t    instruction_memory_data;
	addr_t    instruction_memory_address_out;
	logic     instruction_memory_success;
	logic     instruction_will_queue;
	addr_t    data_memory_address;
	word_t    data_memory_in;
	logic     data_memory_read_req;
	logic     data_memory_write_req;
	wr_mask_t data_memory_wr_mask;
	word_t    data_memory_data_out;
	logic     data_memory_success;
	logic     data_memory_was_requested;
	wr_mask_t data_memory_wr_mask_out;
	logic     bank_sw;
	logic     halt;
	addr_t    ext_address;
	word_t    ext_data_in;
	logic     ext_wr;
	wr_mask_t ext_wr_mask;
	logic     ext_valid;
	logic     ext_rdy;
	word_t    ext_data_out;

	// Reference contents of both banks
	word_t model [2*`SLURM_BANK_WORDS];

	// Loaded vectors
	string       vport [$];
	string       vop [$];
	logic [31:0] vaddr [$];
	logic [31:0] vdata [$];
	logic [31:0] vmask [$];
	logic [31:0] vexp [$];
	logic        load_done = 1'b0;

	int          mismatch_count = 0;
	int          other_count = 0;
	logic [31:0] rng_state = 32'h8d480f3b;
	logic        last_bank = 1'b0;
	logic        any_cpu_access = 1'b0;
	addr_t       rand_addrs [$];

	memory_subsystem_top u_dut (.*);

	always #20 CLK = ~CLK;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string msg);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
			mismatch_count++;
		end
	endtask

	// Byte lanes follow the write mask
	task automatic model_write(input addr_t a, input word_t d, input wr_mask_t m);
		if (m[0])
			model[a][7:0] = d[7:0];
		if (m[1])
			model[a][15:8] = d[15:8];
	endtask

	task automatic cpu_issue(input logic instr, input logic wr, input addr_t a,
		input word_t d, input wr_mask_t m, input logic keep_bank);
		@(posedge CLK);
		// Halt low keeps the bank between CPU accesses
		halt <= !keep_bank;
		if (instr) begin
			instruction_memory_address  <= a;
			instruction_memory_read_req <= 1'b1;
		end else begin
			data_memory_address   <= a;
			data_memory_in        <= d;
			data_memory_wr_mask   <= m;
			data_memory_read_req  <= !wr;
			data_memory_write_req <= wr;
		end
	endtask

	// Wait for success, check it, then drop the request
	task automatic cpu_finish(input logic instr, input logic wr, input addr_t a,
		input word_t d, input wr_mask_t m, input word_t exp);
		int   cycles;
		logic done;
		logic saw_sw;
		cycles = 0;
		done = 1'b0;
		saw_sw = 1'b0;
		while (!done && cycles < REQ_LIMIT) begin
			@(negedge CLK);
			cycles++;
			if (bank_sw)
				saw_sw = 1'b1;
			done = instr ? instruction_memory_success : data_memory_success;
		end
		if (!done) begin
			$display("Error at %0t: no success for CPU access to %h within %0d cycles",
				$time, a, REQ_LIMIT);
			other_count++;
		end else begin
			// Stage 2 holds a data request only on the data channel
			check_value(32'(data_memory_was_requested), 32'(!instr), "data was_requested");
			if (wr) begin
				model_write(a, d, m);
			end else if (instr) begin
				check_value(32'(instruction_memory_data), 32'(model[a]), "fetch data vs model");
				check_value(32'(instruction_memory_data), 32'(exp), "fetch data vs vector");
				check_value(32'(instruction_memory_address_out), 32'(a), "fetch address out");
			end else begin
				check_value(32'(data_memory_data_out), 32'(model[a]), "data read vs model");
				check_value(32'(data_memory_data_out), 32'(exp), "data read vs vector");
				check_value(32'(data_memory_wr_mask_out), 32'(m), "data mask out");
			end
		end
		// Crossing into the other bank must pass through bank_sw
		if (any_cpu_access && (last_bank != a[14]))
			check_value(32'(saw_sw), 32'd1, "bank_sw on bank crossing");
		last_bank = a[14];
		any_cpu_access = 1'b1;
		@(posedge CLK);
		instruction_memory_read_req <= 1'b0;
		data_memory_read_req        <= 1'b0;
		data_memory_write_req       <= 1'b0;
		repeat (3) @(posedge CLK);
	endtask

	task automatic ext_acquire(input addr_t a);
		int cycles;
		cycles = 0;
		@(posedge CLK);
		// CPU gives up its bank once idle
		halt        <= 1'b1;
		ext_address <= a;
		ext_valid   <= 1'b1;
		ext_wr      <= 1'b0;
		@(negedge CLK);
		while (!ext_rdy && cycles < REQ_LIMIT) begin
			@(negedge CLK);
			cycles++;
		end
		if (!ext_rdy) begin
			$display("Error at %0t: external master never got bank for %h", $time, a);
			other_count++;
		end
	endtask

	task automatic ext_release();
		@(posedge CLK);
		ext_valid <= 1'b0;
		repeat (2) @(posedge CLK);
	endtask

	// Caller already holds the bank
	task automatic ext_write_word(input addr_t a, input word_t d, input wr_mask_t m);
		@(posedge CLK);
		ext_address <= a;
		ext_data_in <= d;
		ext_wr_mask <= m;
		ext_wr      <= 1'b1;
		@(posedge CLK);
		ext_wr <= 1'b0;
		model_write(a, d, m);
	endtask

	task automatic ext_read(input addr_t a, input word_t exp, input logic use_exp);
		ext_acquire(a);
		// One cycle of read latency after the grant
		@(negedge CLK);
		check_value(32'(ext_data_out), 32'(model[a]), "ext read vs model");
		if (use_exp)
			check_value(32'(ext_data_out), 32'(exp), "ext read vs vector");
		ext_release();
	endtask

	// Hold a bank, write into it, and stall a CPU read there meanwhile
	task automatic ext_hold(input addr_t a, input word_t d, input wr_mask_t m,
		input word_t exp);
		addr_t ra;
		ext_acquire(a);
		ext_write_word(a, d, m);
		repeat (4) begin
			rng_state = xorshift32(rng_state);
			ra = {3'b101, rng_state[11:0]};
			rand_addrs.push_back(ra);
			ext_write_word(ra, rng_state[31:16], 2'b11);
		end
		cpu_issue(1'b0, 1'b0, a, 16'h0000, m, 1'b0);
		// Idle to request_bank takes one edge
		@(posedge CLK);
		repeat (8) begin
			@(negedge CLK);
			check_value(32'(bank_sw), 32'd1, "bank_sw while bank held");
			check_value(32'(data_memory_success), 32'd0, "no success while bank held");
		end
		@(posedge CLK);
		ext_valid <= 1'b0;
		cpu_finish(1'b0, 1'b0, a, 16'h0000, m, exp);
		while (rand_addrs.size() > 0)
			ext_read(rand_addrs.pop_front(), 16'h0000, 1'b0);
	endtask

	initial begin
		int          fd;
		string       line;
		string       p;
		string       o;
		logic [31:0] ta;
		logic [31:0] td;
		logic [31:0] tm;
		logic [31:0] te;
		CLK = 1'b0;
		RSTb = 1'b0;
		instruction_memory_address = '0;
		instruction_memory_read_req = 1'b0;
		data_memory_address = '0;
		data_memory_in = '0;
		data_memory_read_req = 1'b0;
		data_memory_write_req = 1'b0;
		data_memory_wr_mask = '0;
		// Halt lets the interface drop its bank between accesses
		halt = 1'b1;
		ext_address = '0;
		ext_data_in = '0;
		ext_wr = 1'b0;
		ext_wr_mask = '0;
		ext_valid = 1'b0;
		fd = $fopen("bench/memory_subsystem_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file");
			$display("SIMULATION FAILED");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line[0] != "#" &&
					$sscanf(line, "%s %s %h %h %h %h", p, o, ta, td, tm, te) == 6) begin
					vport.push_back(p);
					vop.push_back(o);
					vaddr.push_back(ta);
					vdata.push_back(td);
					vmask.push_back(tm);
					vexp.push_back(te);
				end
			end
			$fclose(fd);
			load_done = 1'b1;

			repeat (4) @(posedge CLK);
			RSTb <= 1'b1;
			@(negedge CLK);
			// Quiet outputs straight after reset
			check_value(32'(bank_sw), 32'd0, "bank_sw after reset");
			check_value(32'(data_memory_success), 32'd0, "data success after reset");
			check_value(32'(instruction_memory_success), 32'd0, "fetch success after reset");
			check_value(32'(ext_rdy), 32'd0, "ext_rdy after reset");
			check_value(32'(instruction_will_queue), 32'd0, "will_queue after reset");

			foreach (vport[i]) begin
				if (vport[i] == "cpu-data" || vport[i] == "cpu-instr") begin
					cpu_issue(vport[i] == "cpu-instr", vop[i] == "write", vaddr[i][14:0],
						vdata[i][15:0], vmask[i][1:0], 1'b1);
					cpu_finish(vport[i] == "cpu-instr", vop[i] == "write", vaddr[i][14:0],
						vdata[i][15:0], vmask[i][1:0], vexp[i][15:0]);
				end else if (vport[i] == "ext" && vop[i] == "write") begin
					ext_acquire(vaddr[i][14:0]);
					ext_write_word(vaddr[i][14:0], vdata[i][15:0], vmask[i][1:0]);
					ext_release();
				end else if (vport[i] == "ext" && vop[i] == "read") begin
					ext_read(vaddr[i][14:0], vexp[i][15:0], 1'b1);
				end else if (vport[i] == "ext" && vop[i] == "hold-bank") begin
					ext_hold(vaddr[i][14:0], vdata[i][15:0], vmask[i][1:0], vexp[i][15:0]);
				end else begin
					$display("Unknown vector %0d: %s %s", i, vport[i], vop[i]);
					other_count++;
				end
			end

			$display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
			if (mismatch_count == 0 && other_count == 0)
				$display("SIMULATION PASSED");
			else
				$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Run limit scales with the number of vectors
	initial begin
		wait (load_done);
		#((vport.size() * 64 + 4) * 40);
		$display("Watchdog expired before all vectors finished");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- bench/memory_subsystem_vectors.txt
# port op address data mask expected (hex)
# expected is only checked for read and hold-bank rows
cpu-data write 0010 1234 3 0000
cpu-data write 0010 abcd 1 0000
cpu-data read 0010 0000 0 12cd
cpu-data write 0011 5a5a 3 0000
cpu-data write 0011 ff00 2 0000
cpu-data read 0011 0000 2 ff5a
cpu-data write 0012 c3c3 3 0000
cpu-data write 0012 0000 0 0000
cpu-data read 0012 0000 1 c3c3
cpu-data write 4010 beef 3 0000
cpu-data write 4011 0102 3 0000
cpu-instr read 0010 0000 0 12cd
cpu-instr read 4010 0000 0 beef
cpu-data read 4011 0000 3 0102
cpu-data read 0011 0000 3 ff5a
cpu-data read 4010 0000 3 beef
cpu-data read 0012 0000 3 c3c3
ext hold-bank 4020 7777 3 7777
ext write 0030 9abc 3 0000
cpu-data write 0030 0011 2 0000
ext read 0030 0000 0 00bc
cpu-data read 0030 0000 0 00bc
ext read 4020 0000 0 7777
cpu-instr read 4011 0000 0 0102

//--- memory_subsystem_top.f
+incdir+include
design/slurm16_mem_pkg.sv
design/memory_bank.sv
design/bank_arbiter.sv
design/cpu_memory_interface.sv
design/memory_subsystem_top.sv
bench/memory_subsystem_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= memory_subsystem_tb
FILELIST  ?= memory_subsystem_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION PASSED" $(LOG); then \
		echo "test: pass"; \
	else \
		echo "test: fail"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
